//--- include/periph_defs.svh
// Register map, bus widths and engine timing defaults, included by the RTL that needs them.
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths.
`define PERIPH_ADDR_W 8
`define PERIPH_DATA_W 32

// ##########################################################################
// Register map
// ##########################################################################

`define REG_UART_TX  8'h00 // Write only, low byte is sent.
`define REG_SPI_DATA 8'h04 // Write starts an exchange, read gives the last byte.
`define REG_STATUS   8'h08 // Read only.

// Status bit positions.
`define STATUS_UART_BUSY 0
`define STATUS_SPI_BUSY  1

// ##########################################################################
// Engine timing
// ##########################################################################

`define UART_CLKS_PER_BIT 8 // Clock cycles per UART bit.
`define SPI_HALF_PERIOD   2 // Clock cycles per SPI clock phase.

`endif

//--- logic/periph_pkg.sv
// Shared state and response types for the peripheral subsystem, referenced by scoped name.
`default_nettype none

package periph_pkg;

    // UART transmitter states.
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_e;

    // SPI master states.
    typedef enum logic [1:0] {
        SPI_IDLE   = 2'd0,
        SPI_LOW    = 2'd1, // Clock low, MOSI settles.
        SPI_HIGH   = 2'd2, // Clock high.
        SPI_FINISH = 2'd3  // Chip select hold before release.
    } spi_state_e;

    // Register port response codes.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } bus_resp_e;

endpackage

`default_nettype wire

//--- logic/uart_tx.sv
// UART transmitter that sends one 8N1 frame for each byte taken on its start handshake.
`timescale 1ns/1ns
`default_nettype none

`include "periph_defs.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       start_valid_i,
    input  logic [7:0] start_data_i,
    output logic       start_ready_o,
    output logic       uart_tx_o
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    periph_pkg::uart_state_e state_q;
    logic [CNT_W-1:0]        cnt_q;
    logic [2:0]              bit_q;
    logic [7:0]              shift_q;
    logic                    tx_q;
    logic                    bit_done;
    logic                    start_fire;

    assign start_ready_o = (state_q == periph_pkg::UART_IDLE);
    assign start_fire    = start_valid_i && start_ready_o;
    assign bit_done      = (cnt_q == CNT_LAST);
    assign uart_tx_o     = tx_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= periph_pkg::UART_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_q    <= 1'b1; // Line idles high.
        end else begin
            cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
            case (state_q)
                periph_pkg::UART_IDLE: begin
                    cnt_q <= '0;
                    if (start_fire) begin
                        state_q <= periph_pkg::UART_START;
                        tx_q    <= 1'b0;
                    end
                end
                periph_pkg::UART_START: begin
                    if (bit_done) begin
                        state_q <= periph_pkg::UART_DATA;
                        tx_q    <= shift_q[0];
                        bit_q   <= '0;
                    end
                end
                periph_pkg::UART_DATA: begin
                    if (bit_done) begin
                        if (bit_q == 3'd7) begin
                            state_q <= periph_pkg::UART_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_q <= bit_q + 1'b1;
                            tx_q  <= shift_q[0];
                        end
                    end
                end
                periph_pkg::UART_STOP: begin
                    if (bit_done) state_q <= periph_pkg::UART_IDLE;
                end
                default: state_q <= periph_pkg::UART_IDLE;
            endcase
        end
    end

    // Shifted right so the next bit always sits at position 0.
    always_ff @(posedge clk_i) begin
        if (start_fire) begin
            shift_q <= start_data_i;
        end else if (bit_done && (state_q == periph_pkg::UART_START ||
                                  state_q == periph_pkg::UART_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    // A byte held off by a frame in flight waits unchanged until idle takes it.
    a_start_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (start_valid_i && !start_ready_o) |=> start_valid_i && $stable(start_data_i));

endmodule

`default_nettype wire

//--- logic/spi_master.sv
// SPI mode-0 master that exchanges one byte MSB first for each accepted start request.
`timescale 1ns/1ns
`default_nettype none

`include "periph_defs.svh"

module spi_master #(
    parameter int HALF_PERIOD = `SPI_HALF_PERIOD
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       start_valid_i,
    input  logic [7:0] start_data_i,
    output logic       start_ready_o,
    output logic [7:0] rx_data_o,
    output logic       spi_clk_o,
    output logic       spi_mosi_o,
    input  logic       spi_miso_i,
    output logic       spi_cs_n_o
);

    localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF_PERIOD - 1);

    periph_pkg::spi_state_e state_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [2:0]             bit_q;
    logic [7:0]             shift_q;
    logic [7:0]             rx_q;
    logic                   miso_q;
    logic                   sclk_q;
    logic                   cs_n_q;
    logic                   half_done;
    logic                   start_fire;

    assign start_ready_o = (state_q == periph_pkg::SPI_IDLE);
    assign start_fire    = start_valid_i && start_ready_o;
    assign half_done     = (cnt_q == CNT_LAST);

    assign rx_data_o  = rx_q;
    assign spi_clk_o  = sclk_q;
    assign spi_cs_n_o = cs_n_q;
    assign spi_mosi_o = cs_n_q ? 1'b0 : shift_q[7]; // Quiet while deselected.

    // ##########################################################################
    // Sequencing
    // ##########################################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= periph_pkg::SPI_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            sclk_q  <= 1'b0;
            cs_n_q  <= 1'b1;
            rx_q    <= '0;
        end else begin
            cnt_q <= half_done ? '0 : cnt_q + 1'b1;
            case (state_q)
                periph_pkg::SPI_IDLE: begin
                    cnt_q <= '0;
                    if (start_fire) begin
                        state_q <= periph_pkg::SPI_LOW;
                        cs_n_q  <= 1'b0;
                        bit_q   <= '0;
                    end
                end
                periph_pkg::SPI_LOW: begin
                    if (half_done) begin
                        state_q <= periph_pkg::SPI_HIGH;
                        sclk_q  <= 1'b1; // Rising edge.
                    end
                end
                periph_pkg::SPI_HIGH: begin
                    if (half_done) begin
                        sclk_q <= 1'b0;
                        if (bit_q == 3'd7) begin
                            state_q <= periph_pkg::SPI_FINISH;
                        end else begin
                            state_q <= periph_pkg::SPI_LOW;
                            bit_q   <= bit_q + 1'b1;
                        end
                    end
                end
                periph_pkg::SPI_FINISH: begin
                    if (half_done) begin
                        state_q <= periph_pkg::SPI_IDLE;
                        cs_n_q  <= 1'b1;
                        rx_q    <= shift_q;
                    end
                end
                default: state_q <= periph_pkg::SPI_IDLE;
            endcase
        end
    end

    // MISO is caught on the rising edge and shifted in on the falling edge.
    always_ff @(posedge clk_i) begin
        if (start_fire) begin
            shift_q <= start_data_i;
        end else if (half_done && state_q == periph_pkg::SPI_HIGH) begin
            shift_q <= {shift_q[6:0], miso_q};
        end
        if (half_done && state_q == periph_pkg::SPI_LOW) begin
            miso_q <= spi_miso_i;
        end
    end

    a_clk_idle_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        spi_cs_n_o |-> !spi_clk_o);

endmodule

`default_nettype wire

//--- logic/reg_bridge.sv
// Register bridge that decodes host reads and writes and steers them to the UART and SPI engines.
`timescale 1ns/1ns
`default_nettype none

`include "periph_defs.svh"

module reg_bridge (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Host write request and response.
    input  logic                        wr_valid_i,
    input  logic [`PERIPH_ADDR_W-1:0]   wr_addr_i,
    input  logic [`PERIPH_DATA_W-1:0]   wr_data_i,
    output logic                        wr_ready_o,
    output logic                        wr_resp_valid_o,
    output periph_pkg::bus_resp_e       wr_resp_o,
    input  logic                        wr_resp_ready_i,
    // Host read request and response.
    input  logic                        rd_valid_i,
    input  logic [`PERIPH_ADDR_W-1:0]   rd_addr_i,
    output logic                        rd_ready_o,
    output logic                        rd_resp_valid_o,
    output logic [`PERIPH_DATA_W-1:0]   rd_data_o,
    output periph_pkg::bus_resp_e       rd_resp_o,
    input  logic                        rd_resp_ready_i,
    // Engines.
    output logic                        uart_valid_o,
    output logic [7:0]                  uart_data_o,
    input  logic                        uart_ready_i,
    output logic                        spi_valid_o,
    output logic [7:0]                  spi_data_o,
    input  logic                        spi_ready_i,
    input  logic [7:0]                  spi_rx_data_i
);

    logic                      wr_is_uart;
    logic                      wr_is_spi;
    logic                      wr_target_ready;
    logic                      wr_fire;
    logic                      wr_resp_valid_q;
    periph_pkg::bus_resp_e     wr_resp_q;

    logic                      rd_fire;
    logic                      rd_resp_valid_q;
    logic [`PERIPH_DATA_W-1:0] rd_data_q;
    logic [`PERIPH_DATA_W-1:0] rd_data_next;
    logic [`PERIPH_DATA_W-1:0] status_word;
    periph_pkg::bus_resp_e     rd_resp_q;
    periph_pkg::bus_resp_e     rd_resp_next;

    // ##########################################################################
    // Write path
    // ##########################################################################

    assign wr_is_uart = (wr_addr_i == `REG_UART_TX);
    assign wr_is_spi  = (wr_addr_i == `REG_SPI_DATA);

    // Unmapped and read-only addresses never stall.
    assign wr_target_ready = wr_is_uart ? uart_ready_i : (wr_is_spi ? spi_ready_i : 1'b1);
    assign wr_ready_o      = !wr_resp_valid_q && wr_target_ready;
    assign wr_fire         = wr_valid_i && wr_ready_o;

    assign uart_valid_o = wr_valid_i && !wr_resp_valid_q && wr_is_uart;
    assign spi_valid_o  = wr_valid_i && !wr_resp_valid_q && wr_is_spi;
    assign uart_data_o  = wr_data_i[7:0];
    assign spi_data_o   = wr_data_i[7:0];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_resp_valid_q <= 1'b0;
        end else if (wr_fire) begin
            wr_resp_valid_q <= 1'b1;
        end else if (wr_resp_ready_i) begin
            wr_resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            wr_resp_q <= (wr_is_uart || wr_is_spi) ? periph_pkg::RESP_OKAY
                                                   : periph_pkg::RESP_SLVERR;
        end
    end

    assign wr_resp_valid_o = wr_resp_valid_q;
    assign wr_resp_o       = wr_resp_q;

    // ##########################################################################
    // Read path
    // ##########################################################################

    always_comb begin
        status_word = '0;
        status_word[`STATUS_UART_BUSY] = !uart_ready_i;
        status_word[`STATUS_SPI_BUSY]  = !spi_ready_i;
    end

    always_comb begin
        rd_data_next = '0;
        rd_resp_next = periph_pkg::RESP_OKAY;
        case (rd_addr_i)
            `REG_SPI_DATA: rd_data_next[7:0] = spi_rx_data_i;
            `REG_STATUS:   rd_data_next = status_word;
            default:       rd_resp_next = periph_pkg::RESP_SLVERR; // Includes write-only TX.
        endcase
    end

    assign rd_ready_o = !rd_resp_valid_q;
    assign rd_fire    = rd_valid_i && rd_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_resp_valid_q <= 1'b0;
        end else if (rd_fire) begin
            rd_resp_valid_q <= 1'b1;
        end else if (rd_resp_ready_i) begin
            rd_resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rd_data_q <= rd_data_next; // Status is sampled here.
            rd_resp_q <= rd_resp_next;
        end
    end

    assign rd_resp_valid_o = rd_resp_valid_q;
    assign rd_data_o       = rd_data_q;
    assign rd_resp_o       = rd_resp_q;

    // Responses hold under back-pressure.
    a_wr_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_resp_valid_o && !wr_resp_ready_i) |=> wr_resp_valid_o && $stable(wr_resp_o));

    a_rd_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd_resp_valid_o && !rd_resp_ready_i) |=>
            rd_resp_valid_o && $stable(rd_data_o) && $stable(rd_resp_o));

endmodule

`default_nettype wire

//--- logic/periph_top.sv
// Peripheral top level joining the register bridge to the UART and SPI engines and their pins.
`timescale 1ns/1ns
`default_nettype none

`include "periph_defs.svh"

module periph_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  logic                        wr_valid_i,
    input  logic [`PERIPH_ADDR_W-1:0]   wr_addr_i,
    input  logic [`PERIPH_DATA_W-1:0]   wr_data_i,
    output logic                        wr_ready_o,
    output logic                        wr_resp_valid_o,
    output periph_pkg::bus_resp_e       wr_resp_o,
    input  logic                        wr_resp_ready_i,

    input  logic                        rd_valid_i,
    input  logic [`PERIPH_ADDR_W-1:0]   rd_addr_i,
    output logic                        rd_ready_o,
    output logic                        rd_resp_valid_o,
    output logic [`PERIPH_DATA_W-1:0]   rd_data_o,
    output periph_pkg::bus_resp_e       rd_resp_o,
    input  logic                        rd_resp_ready_i,

    output logic                        uart_tx_o,

    output logic                        spi_clk_o,
    output logic                        spi_mosi_o,
    input  logic                        spi_miso_i,
    output logic                        spi_cs_n_o
);

    logic       uart_valid;
    logic [7:0] uart_data;
    logic       uart_ready;

    logic       spi_valid;
    logic [7:0] spi_data;
    logic       spi_ready;
    logic [7:0] spi_rx_data;

    reg_bridge i_reg_bridge (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wr_valid_i     (wr_valid_i),
        .wr_addr_i      (wr_addr_i),
        .wr_data_i      (wr_data_i),
        .wr_ready_o     (wr_ready_o),
        .wr_resp_valid_o(wr_resp_valid_o),
        .wr_resp_o      (wr_resp_o),
        .wr_resp_ready_i(wr_resp_ready_i),
        .rd_valid_i     (rd_valid_i),
        .rd_addr_i      (rd_addr_i),
        .rd_ready_o     (rd_ready_o),
        .rd_resp_valid_o(rd_resp_valid_o),
        .rd_data_o      (rd_data_o),
        .rd_resp_o      (rd_resp_o),
        .rd_resp_ready_i(rd_resp_ready_i),
        .uart_valid_o   (uart_valid),
        .uart_data_o    (uart_data),
        .uart_ready_i   (uart_ready),
        .spi_valid_o    (spi_valid),
        .spi_data_o     (spi_data),
        .spi_ready_i    (spi_ready),
        .spi_rx_data_i  (spi_rx_data)
    );

    uart_tx #(
        .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
    ) i_uart_tx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_valid_i(uart_valid),
        .start_data_i (uart_data),
        .start_ready_o(uart_ready),
        .uart_tx_o    (uart_tx_o)
    );

    spi_master #(
        .HALF_PERIOD(`SPI_HALF_PERIOD)
    ) i_spi_master (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_valid_i(spi_valid),
        .start_data_i (spi_data),
        .start_ready_o(spi_ready),
        .rx_data_o    (spi_rx_data),
        .spi_clk_o    (spi_clk_o),
        .spi_mosi_o   (spi_mosi_o),
        .spi_miso_i   (spi_miso_i),
        .spi_cs_n_o   (spi_cs_n_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_periph_top.sv
// Testbench for periph_top that drives the register port, loops SPI back and decodes the UART line.
`timescale 1ns/1ns
`default_nettype none

`include "periph_defs.svh"

module tb_periph_top;

    localparam int TIMEOUT = 2000; // Cycles allowed for any single wait.

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      wr_valid_i;
    logic [`PERIPH_ADDR_W-1:0] wr_addr_i;
    logic [`PERIPH_DATA_W-1:0] wr_data_i;
    logic                      wr_ready_o;
    logic                      wr_resp_valid_o;
    periph_pkg::bus_resp_e     wr_resp_o;
    logic                      wr_resp_ready_i;
    logic                      rd_valid_i;
    logic [`PERIPH_ADDR_W-1:0] rd_addr_i;
    logic                      rd_ready_o;
    logic                      rd_resp_valid_o;
    logic [`PERIPH_DATA_W-1:0] rd_data_o;
    periph_pkg::bus_resp_e     rd_resp_o;
    logic                      rd_resp_ready_i;
    logic                      uart_tx_o;
    logic                      spi_clk_o;
    logic                      spi_mosi_o;
    logic                      spi_cs_n_o;

    int                        errors = 0;
    logic [31:0]               lcg_state = 32'ha8be54a9;
    periph_pkg::bus_resp_e     exp_wr_resp;
    periph_pkg::bus_resp_e     exp_rd_resp;
    logic [`PERIPH_DATA_W-1:0] exp_rd_data;
    logic [`PERIPH_DATA_W-1:0] exp_rd_mask;
    logic [7:0]                uart_queue[$]; // Bytes accepted but not yet seen on the line.
    logic [7:0]                exp_uart_byte;
    logic [7:0]                uart_byte;
    logic                      uart_framing_ok;
    logic                      uart_in_frame;
    logic                      uart_frame_done;
    int                        uart_frames;
    logic                      rst_q;
    logic                      wr_hold_q;
    logic                      rd_hold_q;
    periph_pkg::bus_resp_e     wr_resp_q;
    periph_pkg::bus_resp_e     rd_resp_q;
    logic [`PERIPH_DATA_W-1:0] rd_data_q;
    logic                      spi_clk_q;
    logic                      spi_cs_n_q;
    int                        spi_rises = 0;

    periph_top i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wr_valid_i     (wr_valid_i),
        .wr_addr_i      (wr_addr_i),
        .wr_data_i      (wr_data_i),
        .wr_ready_o     (wr_ready_o),
        .wr_resp_valid_o(wr_resp_valid_o),
        .wr_resp_o      (wr_resp_o),
        .wr_resp_ready_i(wr_resp_ready_i),
        .rd_valid_i     (rd_valid_i),
        .rd_addr_i      (rd_addr_i),
        .rd_ready_o     (rd_ready_o),
        .rd_resp_valid_o(rd_resp_valid_o),
        .rd_data_o      (rd_data_o),
        .rd_resp_o      (rd_resp_o),
        .rd_resp_ready_i(rd_resp_ready_i),
        .uart_tx_o      (uart_tx_o),
        .spi_clk_o      (spi_clk_o),
        .spi_mosi_o     (spi_mosi_o),
        .spi_miso_i     (spi_mosi_o), // Loopback.
        .spi_cs_n_o     (spi_cs_n_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Previous-cycle copies for the hold checks.
    always @(posedge clk_i) begin
        rst_q     <= rst_n_i;
        wr_hold_q <= wr_resp_valid_o && !wr_resp_ready_i;
        rd_hold_q <= rd_resp_valid_o && !rd_resp_ready_i;
        wr_resp_q <= wr_resp_o;
        rd_resp_q <= rd_resp_o;
        rd_data_q <= rd_data_o;
    end

    // SPI clock rising edges seen while chip select is low.
    always @(posedge clk_i) begin
        spi_clk_q  <= spi_clk_o;
        spi_cs_n_q <= spi_cs_n_o;
        if (spi_cs_n_o) begin
            spi_rises <= 0;
        end else if (spi_clk_o && !spi_clk_q) begin
            spi_rises <= spi_rises + 1;
        end
    end

    // ##########################################################################
    // Checks
    // ##########################################################################

    a_reset_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rst_q |-> wr_ready_o && rd_ready_o && !wr_resp_valid_o && !rd_resp_valid_o &&
                   uart_tx_o && spi_cs_n_o && !spi_clk_o)
        else begin
            errors++;
            $write("ERROR reset state wr_ready_o=%h rd_ready_o=%h wr_resp_valid_o=%h ",
                   $sampled(wr_ready_o), $sampled(rd_ready_o), $sampled(wr_resp_valid_o));
            $display("rd_resp_valid_o=%h uart_tx_o=%h spi_cs_n_o=%h spi_clk_o=%h",
                     $sampled(rd_resp_valid_o), $sampled(uart_tx_o), $sampled(spi_cs_n_o),
                     $sampled(spi_clk_o));
        end

    a_wr_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_resp_valid_o && wr_resp_ready_i) |-> wr_resp_o == exp_wr_resp)
        else begin
            errors++;
            $display("ERROR wr_resp_o got %h expected %h", $sampled(wr_resp_o),
                     $sampled(exp_wr_resp));
        end

    a_rd_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd_resp_valid_o && rd_resp_ready_i) |-> (rd_data_o & exp_rd_mask) == exp_rd_data)
        else begin
            errors++;
            $display("ERROR rd_data_o got %h expected %h under mask %h", $sampled(rd_data_o),
                     $sampled(exp_rd_data), $sampled(exp_rd_mask));
        end

    a_rd_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd_resp_valid_o && rd_resp_ready_i) |-> rd_resp_o == exp_rd_resp)
        else begin
            errors++;
            $display("ERROR rd_resp_o got %h expected %h", $sampled(rd_resp_o),
                     $sampled(exp_rd_resp));
        end

    a_wr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_hold_q |-> wr_resp_valid_o && wr_resp_o == wr_resp_q)
        else begin
            errors++;
            $display("ERROR wr_resp_o not held, was %h now %h", $sampled(wr_resp_q),
                     $sampled(wr_resp_o));
        end

    a_rd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_hold_q |-> rd_resp_valid_o && rd_data_o == rd_data_q && rd_resp_o == rd_resp_q)
        else begin
            errors++;
            $display("ERROR rd_data_o/rd_resp_o not held, was %h/%h now %h/%h",
                     $sampled(rd_data_q), $sampled(rd_resp_q), $sampled(rd_data_o),
                     $sampled(rd_resp_o));
        end

    a_uart_byte: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        uart_frame_done |-> uart_byte == exp_uart_byte)
        else begin
            errors++;
            $display("ERROR uart_tx_o byte got %h expected %h", $sampled(uart_byte),
                     $sampled(exp_uart_byte));
        end

    a_uart_frame: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        uart_frame_done |-> uart_framing_ok)
        else begin
            errors++;
            $display("UART frame has a bad start or stop bit.");
        end

    // Eight clock periods per exchange.
    a_spi_clocks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (spi_cs_n_o && !spi_cs_n_q) |-> spi_rises == 8)
        else begin
            errors++;
            $display("ERROR spi_clk_o rising edges got %h expected %h", $sampled(spi_rises), 8);
        end

    // A busy engine must hold off a new write to its own register.
    a_uart_block: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_valid_i && wr_addr_i == `REG_UART_TX && uart_in_frame) |-> !wr_ready_o)
        else begin
            errors++;
            $display("UART write was accepted while a frame was on the line.");
        end

    a_spi_block: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_valid_i && wr_addr_i == `REG_SPI_DATA && !spi_cs_n_o) |-> !wr_ready_o)
        else begin
            errors++;
            $display("SPI write was accepted while chip select was low.");
        end

    // UART line monitor that samples each bit near its middle.
    initial begin
        uart_in_frame   = 1'b0;
        uart_frame_done = 1'b0;
        uart_frames     = 0;
        uart_byte       = '0;
        exp_uart_byte   = '0;
        uart_framing_ok = 1'b0;
        forever begin
            @(negedge clk_i);
            uart_frame_done = 1'b0;
            if (rst_n_i && !uart_tx_o) begin
                uart_in_frame = 1'b1;
                if (uart_queue.size() == 0) begin
                    errors++;
                    $display("UART frame started with no byte written.");
                end else begin
                    exp_uart_byte = uart_queue.pop_front();
                end
                repeat (3) @(negedge clk_i);
                uart_framing_ok = !uart_tx_o;
                for (int i = 0; i < 8; i++) begin
                    repeat (`UART_CLKS_PER_BIT) @(negedge clk_i);
                    uart_byte[i] = uart_tx_o; // LSB first.
                end
                repeat (`UART_CLKS_PER_BIT) @(negedge clk_i);
                uart_framing_ok = uart_framing_ok && uart_tx_o;
                uart_in_frame   = 1'b0;
                uart_frame_done = 1'b1;
                uart_frames++;
            end
        end
    end

    // ##########################################################################
    // Host tasks
    // ##########################################################################

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_timeout(input string what, input logic [7:0] addr);
        errors++;
        $display("Timeout while waiting for the %s at address %h.", what, addr);
    endtask

    // Response ready stays low for a random stretch.
    task automatic stall_cycles();
        int n;
        n = int'((next_rand() >> 16) % 5);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic write_reg(input logic [`PERIPH_ADDR_W-1:0] addr,
                             input logic [`PERIPH_DATA_W-1:0] data,
                             input periph_pkg::bus_resp_e resp);
        int n;
        @(posedge clk_i);
        wr_valid_i  <= 1'b1;
        wr_addr_i   <= addr;
        wr_data_i   <= data;
        exp_wr_resp <= resp;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!wr_ready_o && n < TIMEOUT);
        if (!wr_ready_o) report_timeout("write request", addr);
        @(posedge clk_i);
        wr_valid_i <= 1'b0;
        if (addr == `REG_UART_TX) uart_queue.push_back(data[7:0]);
        stall_cycles();
        wr_resp_ready_i <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!wr_resp_valid_o && n < TIMEOUT);
        if (!wr_resp_valid_o) report_timeout("write response", addr);
        @(posedge clk_i);
        wr_resp_ready_i <= 1'b0;
    endtask

    task automatic read_reg(input logic [`PERIPH_ADDR_W-1:0] addr,
                            input logic [`PERIPH_DATA_W-1:0] exp_data,
                            input logic [`PERIPH_DATA_W-1:0] mask,
                            input periph_pkg::bus_resp_e resp,
                            output logic [`PERIPH_DATA_W-1:0] data);
        int n;
        @(posedge clk_i);
        rd_valid_i  <= 1'b1;
        rd_addr_i   <= addr;
        exp_rd_data <= exp_data & mask;
        exp_rd_mask <= mask;
        exp_rd_resp <= resp;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!rd_ready_o && n < TIMEOUT);
        if (!rd_ready_o) report_timeout("read request", addr);
        @(posedge clk_i);
        rd_valid_i <= 1'b0;
        stall_cycles();
        rd_resp_ready_i <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!rd_resp_valid_o && n < TIMEOUT);
        if (!rd_resp_valid_o) report_timeout("read response", addr);
        data = rd_data_o;
        @(posedge clk_i);
        rd_resp_ready_i <= 1'b0;
    endtask

    // ##########################################################################
    // Stimulus
    // ##########################################################################

    initial begin
        logic [7:0]  b;
        logic [31:0] st;
        int          n;
        rst_n_i         = 1'b0;
        wr_valid_i      = 1'b0;
        wr_addr_i       = '0;
        wr_data_i       = '0;
        wr_resp_ready_i = 1'b0;
        rd_valid_i      = 1'b0;
        rd_addr_i       = '0;
        rd_resp_ready_i = 1'b0;
        exp_wr_resp     = periph_pkg::RESP_OKAY;
        exp_rd_resp     = periph_pkg::RESP_OKAY;
        exp_rd_data     = '0;
        exp_rd_mask     = '0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Second UART write waits for the first frame.
        for (int k = 0; k < 3; k++) begin
            write_reg(`REG_UART_TX, next_rand(), periph_pkg::RESP_OKAY);
            read_reg(`REG_STATUS, 32'h1, 32'h1, periph_pkg::RESP_OKAY, st);
            write_reg(`REG_UART_TX, next_rand(), periph_pkg::RESP_OKAY);
        end
        n = 0;
        while (uart_frames < 6 && n < TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (uart_frames < 6) begin
            errors++;
            $display("Timeout while waiting for the UART frames, saw %0d.", uart_frames);
        end

        for (int k = 0; k < 4; k++) begin
            b = 8'(next_rand());
            write_reg(`REG_SPI_DATA, {24'h0, b}, periph_pkg::RESP_OKAY);
            read_reg(`REG_STATUS, 32'h2, 32'h2, periph_pkg::RESP_OKAY, st);
            if ((k % 2) == 1) begin
                b = 8'(next_rand());
                write_reg(`REG_SPI_DATA, {24'h0, b}, periph_pkg::RESP_OKAY);
            end
            st = 32'h2;
            n  = 0;
            // UART is idle here, so only the SPI busy bit may be set.
            while (st[`STATUS_SPI_BUSY] && n < 100) begin
                read_reg(`REG_STATUS, '0, 32'hffff_fffd, periph_pkg::RESP_OKAY, st);
                n++;
            end
            if (st[`STATUS_SPI_BUSY]) report_timeout("SPI idle status", `REG_STATUS);
            read_reg(`REG_SPI_DATA, {24'h0, b}, 32'hffff_ffff, periph_pkg::RESP_OKAY, st);
        end

        // Unmapped and read-only addresses.
        write_reg(8'h0c, next_rand(), periph_pkg::RESP_SLVERR);
        write_reg(`REG_STATUS, next_rand(), periph_pkg::RESP_SLVERR);
        write_reg(8'(next_rand()) | 8'h10, next_rand(), periph_pkg::RESP_SLVERR);
        read_reg(8'h0c, '0, 32'hffff_ffff, periph_pkg::RESP_SLVERR, st);
        read_reg(8'(next_rand()) | 8'h10, '0, 32'hffff_ffff, periph_pkg::RESP_SLVERR, st);

        repeat (4) @(posedge clk_i);
        $display("Simulation finished with %0d errors.", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
logic/periph_pkg.sv
logic/uart_tx.sv
logic/spi_master.sv
logic/reg_bridge.sv
logic/periph_top.sv
sim/tb_periph_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_periph_top
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
